// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = rename_core_tb
FILELIST  = rename_core.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; a $fatal or a failed assertion gives a nonzero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/rename_core_assertions.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_core_assertions (
    input logic                        clock,
    input logic                        reset,
    input rename_pkg::dispatch_count_t instructions_valid,
    input rename_pkg::dispatch_count_t dispatch_count,
    input logic                        commit_valid,
    input logic                        restore_valid
);

    // ROB occupancy rebuilt from the top-level strobes
    logic [`ROB_COUNT_BITS-1:0] rob_occupancy;

    always_ff @(posedge clock) begin
        if (reset) begin
            rob_occupancy <= '0;
        end else begin
            rob_occupancy <= rob_occupancy + dispatch_count - commit_valid;
        end
    end

    // Flush cycle dispatches nothing
    restore_blocks_dispatch: assert property (@(posedge clock) disable iff (reset)
        restore_valid |-> dispatch_count == '0)
        else $error("dispatch_count is nonzero while restore_valid is high");

    // Never more than the buffer offers
    dispatch_within_valid: assert property (@(posedge clock) disable iff (reset)
        dispatch_count <= instructions_valid)
        else $error("dispatch_count exceeds instructions_valid");

    // ROB comes out of reset empty
    no_commit_after_reset: assert property (@(posedge clock)
        reset |=> !commit_valid)
        else $error("commit_valid is high in the cycle after reset");

    // Restore is a flush of an empty ROB
    restore_on_empty_rob: assert property (@(posedge clock) disable iff (reset)
        restore_valid |-> rob_occupancy == '0)
        else $error("restore_valid is high while the ROB still holds entries");

endmodule

bind rename_core rename_core_assertions assertions_inst (
    .clock              (clock),
    .reset              (reset),
    .instructions_valid (instructions_valid),
    .dispatch_count     (dispatch_count),
    .commit_valid       (commit_valid),
    .restore_valid      (restore_valid)
);

// ==== bench/rename_core_tb.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_core_tb;

    // One table row, applied for one cycle
    typedef struct packed {
        rename_pkg::dispatch_count_t valid;
        logic [`DISPATCH_WIDTH-1:0]  dest_mask;
        logic [`RS_COUNT_BITS-1:0]   rs_available;
        logic                        commit;
        logic                        restore;
    } stim_row;

    localparam int NUM_ROWS = 27;
    localparam int DRAIN_LIMIT = `ROB_DEPTH + 2;

    // valid, has_dest per new slot, RS slots, commit, restore
    localparam stim_row STIM_TABLE [NUM_ROWS] = '{
        // Fresh renames out of reset
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b0},
        '{2'd2, 2'b01, 4'd8, 1'b0, 1'b0},
        // RS limits leave leftovers for later rows
        '{2'd2, 2'b11, 4'd0, 1'b0, 1'b0},
        '{2'd2, 2'b11, 4'd1, 1'b0, 1'b0},
        '{2'd2, 2'b10, 4'd8, 1'b0, 1'b0},
        // Fill the ROB up
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b0},
        // Full ROB frees one slot per commit
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b01, 4'd1, 1'b1, 1'b0},
        '{2'd0, 2'b00, 4'd8, 1'b1, 1'b0},
        // Flush to the snapshot after a drain
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b1},
        // Renames from the snapshot reach recycled registers
        '{2'd2, 2'b11, 4'd8, 1'b0, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b10, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd0, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0},
        '{2'd2, 2'b11, 4'd8, 1'b1, 1'b0}
    };

    logic                                             clock;
    logic                                             reset;
    rename_pkg::instruction_packet [`DISPATCH_WIDTH-1:0] instruction_packets;
    rename_pkg::dispatch_count_t                      instructions_valid;
    rename_pkg::dispatch_count_t                      dispatch_count;
    logic [`RS_COUNT_BITS-1:0]                        rs_entries_available;
    rename_pkg::rs_entry_packet [`DISPATCH_WIDTH-1:0] rs_entries;
    logic                                             commit;
    logic                                             commit_valid;
    rename_pkg::arch_reg_idx                          commit_dest_arch;
    rename_pkg::phys_reg_idx                          commit_new_phys;
    logic                                             restore_valid;
    rename_pkg::map_table_t                           map_table_restore;
    rename_pkg::map_table_t                           map_table_snapshot;

    // Reference model state
    rename_pkg::map_table_t          model_map;
    rename_pkg::map_table_t          restore_map;
    rename_pkg::phys_reg_idx         free_q [$];
    rename_pkg::rob_entry_packet     rob_q [$];
    // Instruction buffer with its head at index 0
    rename_pkg::instruction_packet   inst_q [$];
    rename_pkg::rob_idx              model_tail;
    rename_pkg::arch_reg_idx         last_dest;
    logic [15:0]                     lfsr_state;

    rename_core UUT (
        .clock                (clock),
        .reset                (reset),
        .instruction_packets  (instruction_packets),
        .instructions_valid   (instructions_valid),
        .dispatch_count       (dispatch_count),
        .rs_entries_available (rs_entries_available),
        .rs_entries           (rs_entries),
        .commit               (commit),
        .commit_valid         (commit_valid),
        .commit_dest_arch     (commit_dest_arch),
        .commit_new_phys      (commit_new_phys),
        .restore_valid        (restore_valid),
        .map_table_restore    (map_table_restore),
        .map_table_snapshot   (map_table_snapshot)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Galois LFSR over x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state >> 1;
        if (state[0]) begin
            lfsr_next = lfsr_next ^ 16'hB400;
        end
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int width, output logic [7:0] value);
        value = '0;
        for (int b = 0; b < width; b++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // src1 reads the last renamed destination so groups forward
    task automatic make_instruction(input logic has_dest,
                                    output rename_pkg::instruction_packet inst);
        logic [7:0] bits;
        take_bits(8, bits);
        inst.opcode = bits;
        take_bits(5, bits);
        inst.dest = bits[4:0];
        take_bits(5, bits);
        inst.src2 = bits[4:0];
        inst.src1 = last_dest;
        inst.has_dest = has_dest;
        if (has_dest) begin
            last_dest = inst.dest;
        end
    endtask

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_value_error(input string name, input logic [31:0] got,
                                      input logic [31:0] expected);
        $display("Error %s: got 0x%0h, expected 0x%0h", name, got, expected);
        stop_with_failure();
    endtask

    task automatic check_count(input rename_pkg::dispatch_count_t actual,
                               input rename_pkg::dispatch_count_t expected);
        if (actual !== expected) begin
            report_value_error("dispatch_count", actual, expected);
        end
    endtask

    task automatic check_rs_entry(input int slot, input logic has_dest,
                                  input rename_pkg::rs_entry_packet actual,
                                  input rename_pkg::rs_entry_packet expected);
        rename_pkg::rs_entry_packet got;
        rename_pkg::rs_entry_packet want;
        got = actual;
        want = expected;
        // dest_phys means nothing without a destination
        if (!has_dest) begin
            got.dest_phys = '0;
            want.dest_phys = '0;
        end
        if (got !== want) begin
            report_value_error($sformatf("rs_entries[%0d]", slot), got, want);
        end
    endtask

    task automatic check_commit(input logic valid, input rename_pkg::arch_reg_idx dest_arch,
                                input rename_pkg::phys_reg_idx new_phys,
                                input logic exp_valid,
                                input rename_pkg::arch_reg_idx exp_dest_arch,
                                input rename_pkg::phys_reg_idx exp_new_phys);
        if (valid !== exp_valid) begin
            report_value_error("commit_valid", valid, exp_valid);
        end
        if (exp_valid && dest_arch !== exp_dest_arch) begin
            report_value_error("commit_dest_arch", dest_arch, exp_dest_arch);
        end
        if (exp_valid && new_phys !== exp_new_phys) begin
            report_value_error("commit_new_phys", new_phys, exp_new_phys);
        end
    endtask

    task automatic check_map(input rename_pkg::map_table_t actual,
                             input rename_pkg::map_table_t expected);
        for (int a = 0; a < `ARCH_REGS; a++) begin
            if (actual[a] !== expected[a]) begin
                report_value_error($sformatf("map_table_snapshot[%0d]", a),
                                   actual[a], expected[a]);
            end
        end
    endtask

    // Top up the buffer and present its head on the rising edge
    task automatic drive_inputs(input stim_row row);
        rename_pkg::instruction_packet inst;
        logic [`DISPATCH_WIDTH-1:0] mask;
        mask = row.dest_mask >> inst_q.size();
        while (inst_q.size() < int'(row.valid)) begin
            make_instruction(mask[0], inst);
            mask = mask >> 1;
            inst_q.push_back(inst);
        end
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (i < int'(row.valid)) begin
                instruction_packets[i] <= inst_q[i];
            end else begin
                instruction_packets[i] <= '0;
            end
        end
        instructions_valid <= row.valid;
        rs_entries_available <= row.rs_available;
        commit <= row.commit;
        restore_valid <= row.restore;
    endtask

    // Expected results for the cycle followed by the model's edge update
    task automatic step_model(input stim_row row);
        rename_pkg::map_table_t stage;
        rename_pkg::rs_entry_packet rs_expected;
        rename_pkg::rob_entry_packet entry;
        rename_pkg::rob_entry_packet head;
        rename_pkg::rob_entry_packet new_entries [$];
        rename_pkg::instruction_packet inst;
        rename_pkg::dispatch_count_t k_expected;
        int needed;
        int used;
        int free_limit;
        int rob_free;
        logic commit_expected;

        // Largest prefix that fits every limit
        free_limit = (free_q.size() < `DISPATCH_WIDTH) ? free_q.size() : `DISPATCH_WIDTH;
        rob_free = `ROB_DEPTH - rob_q.size();
        needed = 0;
        k_expected = '0;
        for (int k = 1; k <= int'(row.valid); k++) begin
            if (inst_q[k-1].has_dest) begin
                needed++;
            end
            if (!row.restore && needed <= free_limit && k <= rob_free &&
                k <= int'(row.rs_available)) begin
                k_expected = rename_pkg::dispatch_count_t'(k);
            end
        end
        check_count(dispatch_count, k_expected);

        // In-order rename of the dispatched prefix
        stage = model_map;
        used = 0;
        for (int i = 0; i < int'(k_expected); i++) begin
            inst = inst_q[i];
            rs_expected.opcode = inst.opcode;
            rs_expected.src1_phys = stage[inst.src1];
            rs_expected.src2_phys = stage[inst.src2];
            rs_expected.dest_phys = '0;
            rs_expected.rob_index = rename_pkg::rob_idx'(model_tail + i);
            entry.dest_arch = inst.dest;
            entry.has_dest = inst.has_dest;
            entry.new_phys = '0;
            entry.old_phys = '0;
            if (inst.has_dest) begin
                rs_expected.dest_phys = free_q[used];
                entry.new_phys = free_q[used];
                entry.old_phys = stage[inst.dest];
                stage[inst.dest] = free_q[used];
                used++;
            end
            check_rs_entry(i, inst.has_dest, rs_entries[i], rs_expected);
            new_entries.push_back(entry);
        end

        // Head retires only if the ROB holds something
        head = '0;
        commit_expected = row.commit && (rob_q.size() != 0);
        if (commit_expected) begin
            head = rob_q[0];
        end
        check_commit(commit_valid, commit_dest_arch, commit_new_phys,
                     commit_expected, head.dest_arch, head.new_phys);
        check_map(map_table_snapshot, model_map);

        // Edge update
        model_map = row.restore ? restore_map : stage;
        for (int i = 0; i < used; i++) begin
            void'(free_q.pop_front());
        end
        if (commit_expected) begin
            head = rob_q.pop_front();
            // Freed register queues behind the ones already free
            if (head.has_dest) begin
                free_q.push_back(head.old_phys);
            end
        end
        foreach (new_entries[i]) begin
            rob_q.push_back(new_entries[i]);
        end
        model_tail = model_tail + k_expected;
        for (int i = 0; i < int'(k_expected); i++) begin
            void'(inst_q.pop_front());
        end
    endtask

    // Commit with nothing offered until the ROB reports empty
    task automatic drain_rob();
        stim_row idle_row;
        int cycles;
        idle_row = '{2'd0, 2'b00, 4'd8, 1'b1, 1'b0};
        cycles = 0;
        do begin
            if (cycles == DRAIN_LIMIT) begin
                $display("Timeout: the ROB did not drain in %0d cycles", DRAIN_LIMIT);
                stop_with_failure();
            end
            @(posedge clock);
            drive_inputs(idle_row);
            @(negedge clock);
            step_model(idle_row);
            cycles++;
        end while (commit_valid);
    endtask

    initial begin
        reset = 1'b1;
        instruction_packets = '0;
        instructions_valid = '0;
        rs_entries_available = '0;
        // Commit stays requested through reset while the ROB is empty
        commit = 1'b1;
        restore_valid = 1'b0;
        lfsr_state = 16'd83;
        model_tail = '0;
        last_dest = '0;
        // Identity map and a snapshot reversed over the whole index
        for (int a = 0; a < `ARCH_REGS; a++) begin
            model_map[a] = rename_pkg::phys_reg_idx'(a);
            restore_map[a] = rename_pkg::phys_reg_idx'(`PHYS_REGS - 1 - a);
        end
        map_table_restore = restore_map;
        for (int p = `ARCH_REGS; p < `PHYS_REGS; p++) begin
            free_q.push_back(rename_pkg::phys_reg_idx'(p));
        end

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (STIM_TABLE[r].restore) begin
                drain_rob();
            end
            @(posedge clock);
            drive_inputs(STIM_TABLE[r]);
            @(negedge clock);
            step_model(STIM_TABLE[r]);
        end
        drain_rob();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== common/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Instructions renamed and dispatched per cycle
`define DISPATCH_WIDTH 2

// Register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// ROB size, kept a power of two so the pointers wrap on their own
`define ROB_DEPTH 16

// Largest free-slot count the RS can report
`define RS_SLOTS 8

// Derived index and count widths
`define ARCH_REG_BITS ($clog2(`ARCH_REGS))
`define PHYS_REG_BITS ($clog2(`PHYS_REGS))
`define ROB_BITS ($clog2(`ROB_DEPTH))
`define ROB_COUNT_BITS ($clog2(`ROB_DEPTH + 1))
`define RS_COUNT_BITS ($clog2(`RS_SLOTS + 1))
`define DISPATCH_COUNT_BITS ($clog2(`DISPATCH_WIDTH + 1))
`define FREE_COUNT_BITS ($clog2(`PHYS_REGS + 1))

`endif

// ==== common/rename_pkg.sv ====
`include "rename_config.svh"

package rename_pkg;

    // Register and ROB indices
    typedef logic [`ARCH_REG_BITS-1:0] arch_reg_idx;
    typedef logic [`PHYS_REG_BITS-1:0] phys_reg_idx;
    typedef logic [`ROB_BITS-1:0] rob_idx;

    // Counts 0 up to DISPATCH_WIDTH inclusive
    typedef logic [`DISPATCH_COUNT_BITS-1:0] dispatch_count_t;

    typedef logic [7:0] opcode_t;

    // Decoded instruction from the instruction buffer, 24 bits
    typedef struct packed {
        opcode_t     opcode;
        arch_reg_idx dest;
        arch_reg_idx src1;
        arch_reg_idx src2;
        logic        has_dest;
    } instruction_packet;

    // One in-order ROB slot
    // old_phys goes back to the free list when the entry commits
    typedef struct packed {
        arch_reg_idx dest_arch;
        phys_reg_idx new_phys;
        phys_reg_idx old_phys;
        logic        has_dest;
    } rob_entry_packet;

    // Renamed instruction handed to the reservation stations
    typedef struct packed {
        opcode_t     opcode;
        phys_reg_idx src1_phys;
        phys_reg_idx src2_phys;
        phys_reg_idx dest_phys;
        rob_idx      rob_index;
    } rs_entry_packet;

    // Whole rename map, one physical register per architectural one
    typedef phys_reg_idx [`ARCH_REGS-1:0] map_table_t;

endpackage

// ==== design/rename_core.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_core (
    input  logic                                               clock,
    input  logic                                               reset,

    // Instruction buffer
    input  rename_pkg::instruction_packet [`DISPATCH_WIDTH-1:0] instruction_packets,
    input  rename_pkg::dispatch_count_t                        instructions_valid,
    output rename_pkg::dispatch_count_t                        dispatch_count,

    // Reservation stations
    input  logic [`RS_COUNT_BITS-1:0]                          rs_entries_available,
    output rename_pkg::rs_entry_packet [`DISPATCH_WIDTH-1:0]   rs_entries,

    // Commit
    input  logic                                               commit,
    output logic                                               commit_valid,
    output rename_pkg::arch_reg_idx                            commit_dest_arch,
    output rename_pkg::phys_reg_idx                            commit_new_phys,

    // Branch stack
    input  logic                                               restore_valid,
    input  rename_pkg::map_table_t                             map_table_restore,
    output rename_pkg::map_table_t                             map_table_snapshot
);

    // Free list to dispatch
    rename_pkg::dispatch_count_t                       regs_available;
    rename_pkg::phys_reg_idx [`DISPATCH_WIDTH-1:0]     regs_to_use;
    rename_pkg::dispatch_count_t                       regs_taken;

    // ROB to and from dispatch
    rename_pkg::rob_idx                                rob_tail;
    logic [`ROB_COUNT_BITS-1:0]                        rob_entries_available;
    rename_pkg::rob_entry_packet [`DISPATCH_WIDTH-1:0] rob_entries;

    // Committed old mapping back to the free list
    logic                                              free_valid;
    rename_pkg::phys_reg_idx                           free_reg;

    dispatch dispatch_inst (
        .clock                 (clock),
        .reset                 (reset),
        .instruction_packets   (instruction_packets),
        .instructions_valid    (instructions_valid),
        .restore_valid         (restore_valid),
        .map_table_restore     (map_table_restore),
        .regs_available        (regs_available),
        .regs_to_use           (regs_to_use),
        .rob_tail              (rob_tail),
        .rob_entries_available (rob_entries_available),
        .rs_entries_available  (rs_entries_available),
        .dispatch_count        (dispatch_count),
        .regs_taken            (regs_taken),
        .rob_entries           (rob_entries),
        .rs_entries            (rs_entries),
        .map_table_snapshot    (map_table_snapshot)
    );

    free_list free_list_inst (
        .clock          (clock),
        .reset          (reset),
        .regs_taken     (regs_taken),
        .free_valid     (free_valid),
        .free_reg       (free_reg),
        .regs_to_use    (regs_to_use),
        .regs_available (regs_available)
    );

    reorder_buffer reorder_buffer_inst (
        .clock                 (clock),
        .reset                 (reset),
        .rob_entries           (rob_entries),
        .dispatch_count        (dispatch_count),
        .commit                (commit),
        .rob_tail              (rob_tail),
        .rob_entries_available (rob_entries_available),
        .commit_valid          (commit_valid),
        .commit_dest_arch      (commit_dest_arch),
        .commit_new_phys       (commit_new_phys),
        .free_valid            (free_valid),
        .free_reg              (free_reg)
    );

endmodule

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module reorder_buffer (
    input  logic                                              clock,
    input  logic                                              reset,

    // Allocation from dispatch
    input  rename_pkg::rob_entry_packet [`DISPATCH_WIDTH-1:0] rob_entries,
    input  rename_pkg::dispatch_count_t                       dispatch_count,

    // Retire strobe for the head
    input  logic                                              commit,

    // Space and next slot for dispatch
    output rename_pkg::rob_idx                                rob_tail,
    output logic [`ROB_COUNT_BITS-1:0]                        rob_entries_available,

    // Head being retired this cycle
    output logic                                              commit_valid,
    output rename_pkg::arch_reg_idx                           commit_dest_arch,
    output rename_pkg::phys_reg_idx                           commit_new_phys,

    // Previous mapping returned to the free list
    output logic                                              free_valid,
    output rename_pkg::phys_reg_idx                           free_reg
);

    localparam logic [`ROB_COUNT_BITS-1:0] FULL_COUNT = `ROB_DEPTH;

    // Entry storage, indexed by rob_idx
    rename_pkg::rob_entry_packet entries [`ROB_DEPTH];

    // Oldest entry
    rename_pkg::rob_idx head;
    // Next slot to allocate
    rename_pkg::rob_idx tail;
    // Occupied entries, 0..ROB_DEPTH
    logic [`ROB_COUNT_BITS-1:0] count;

    rename_pkg::rob_entry_packet head_entry;

    assign head_entry = entries[head];

    // Retire only when something is there
    assign commit_valid = commit && (count != '0);

    // Head fields, qualified by commit_valid
    assign commit_dest_arch = head_entry.dest_arch;
    assign commit_new_phys = head_entry.new_phys;

    // Instructions without a destination free nothing
    assign free_valid = commit_valid && head_entry.has_dest;
    assign free_reg = head_entry.old_phys;

    assign rob_tail = tail;
    assign rob_entries_available = FULL_COUNT - count;

    // Pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            tail <= tail + dispatch_count;
            head <= head + commit_valid;
            count <= count + dispatch_count - commit_valid;
        end
    end

    // Allocate the dispatched prefix at the tail
    always_ff @(posedge clock) begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (i < dispatch_count) begin
                entries[rename_pkg::rob_idx'(tail + i)] <= rob_entries[i];
            end
        end
    end

endmodule

// ==== dispatch/dispatch.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module dispatch (
    input  logic                                               clock,
    input  logic                                               reset,

    // Instruction buffer
    input  rename_pkg::instruction_packet [`DISPATCH_WIDTH-1:0] instruction_packets,
    input  rename_pkg::dispatch_count_t                        instructions_valid,

    // Branch stack
    input  logic                                               restore_valid,
    input  rename_pkg::map_table_t                             map_table_restore,

    // Free list
    input  rename_pkg::dispatch_count_t                        regs_available,
    input  rename_pkg::phys_reg_idx [`DISPATCH_WIDTH-1:0]      regs_to_use,

    // ROB and RS space
    input  rename_pkg::rob_idx                                 rob_tail,
    input  logic [`ROB_COUNT_BITS-1:0]                         rob_entries_available,
    input  logic [`RS_COUNT_BITS-1:0]                          rs_entries_available,

    output rename_pkg::dispatch_count_t                        dispatch_count,
    output rename_pkg::dispatch_count_t                        regs_taken,
    output rename_pkg::rob_entry_packet [`DISPATCH_WIDTH-1:0]  rob_entries,
    output rename_pkg::rs_entry_packet [`DISPATCH_WIDTH-1:0]   rs_entries,
    output rename_pkg::map_table_t                             map_table_snapshot
);

    // Index width for picking one of the offered free registers
    localparam int SLOT_BITS = $clog2(`DISPATCH_WIDTH);

    // Architectural to physical map
    rename_pkg::map_table_t map_table;

    // Map as seen by slot i, with the renames of slots 0..i-1 applied
    // Stage DISPATCH_WIDTH is the map after the whole group
    rename_pkg::map_table_t map_stage [`DISPATCH_WIDTH+1];

    // Free registers consumed by the first i slots
    rename_pkg::dispatch_count_t regs_needed [`DISPATCH_WIDTH+1];

    // Chained in-group rename
    always_comb begin
        map_stage[0] = map_table;
        regs_needed[0] = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            map_stage[i+1] = map_stage[i];
            regs_needed[i+1] = regs_needed[i];

            // Sources see earlier renames of this group
            rs_entries[i].opcode = instruction_packets[i].opcode;
            rs_entries[i].src1_phys = map_stage[i][instruction_packets[i].src1];
            rs_entries[i].src2_phys = map_stage[i][instruction_packets[i].src2];
            rs_entries[i].rob_index = rename_pkg::rob_idx'(rob_tail + i);
            rs_entries[i].dest_phys = '0;

            rob_entries[i].dest_arch = instruction_packets[i].dest;
            rob_entries[i].has_dest = instruction_packets[i].has_dest;
            rob_entries[i].new_phys = '0;
            rob_entries[i].old_phys = '0;

            if (instruction_packets[i].has_dest) begin
                // Next free register in free-list order
                rs_entries[i].dest_phys = regs_to_use[regs_needed[i][SLOT_BITS-1:0]];
                rob_entries[i].new_phys = regs_to_use[regs_needed[i][SLOT_BITS-1:0]];
                // Mapping that was live just before this instruction
                rob_entries[i].old_phys = map_stage[i][instruction_packets[i].dest];
                map_stage[i+1][instruction_packets[i].dest] =
                    regs_to_use[regs_needed[i][SLOT_BITS-1:0]];
                regs_needed[i+1] = regs_needed[i] + 1'b1;
            end
        end
    end

    // Longest in-order prefix that fits
    // Every limit grows monotonically with k, so the last k that fits wins
    always_comb begin
        dispatch_count = '0;
        for (int k = 1; k <= `DISPATCH_WIDTH; k++) begin
            if (k <= instructions_valid &&
                regs_needed[k] <= regs_available &&
                k <= rob_entries_available &&
                k <= rs_entries_available) begin
                dispatch_count = rename_pkg::dispatch_count_t'(k);
            end
        end
        // Flush cycle, nothing goes out
        if (restore_valid) begin
            dispatch_count = '0;
        end
    end

    // Registers popped from the free list this cycle
    assign regs_taken = regs_needed[dispatch_count];

    // Map update, identity out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                map_table[a] <= rename_pkg::phys_reg_idx'(a);
            end
        end else if (restore_valid) begin
            map_table <= map_table_restore;
        end else begin
            // Only the dispatched prefix is committed to the map
            map_table <= map_stage[dispatch_count];
        end
    end

    // Current map for the branch stack
    assign map_table_snapshot = map_table;

endmodule

// ==== dispatch/free_list.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module free_list (
    input  logic                                          clock,
    input  logic                                          reset,

    // Pops from dispatch
    input  rename_pkg::dispatch_count_t                   regs_taken,

    // Returned register from ROB commit
    input  logic                                          free_valid,
    input  rename_pkg::phys_reg_idx                       free_reg,

    // Head of the queue offered to dispatch
    output rename_pkg::phys_reg_idx [`DISPATCH_WIDTH-1:0] regs_to_use,
    output rename_pkg::dispatch_count_t                   regs_available
);

    // One slot per physical register, so the queue can never overflow
    // PHYS_REGS is a power of two and the pointers wrap naturally
    localparam int DEPTH = `PHYS_REGS;

    // Registers not mapped after reset
    localparam int INITIAL_FREE = `PHYS_REGS - `ARCH_REGS;

    localparam logic [`FREE_COUNT_BITS-1:0] WIDTH_COUNT = `DISPATCH_WIDTH;

    // Queue storage
    rename_pkg::phys_reg_idx free_regs [DEPTH];

    // Pop side
    rename_pkg::phys_reg_idx head;
    // Push side
    rename_pkg::phys_reg_idx tail;
    logic [`FREE_COUNT_BITS-1:0] count;

    // First DISPATCH_WIDTH entries in pop order
    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            regs_to_use[i] = free_regs[rename_pkg::phys_reg_idx'(head + i)];
        end
    end

    // Clamped so dispatch only sees what it can use in one cycle
    assign regs_available = (count >= WIDTH_COUNT) ?
        rename_pkg::dispatch_count_t'(`DISPATCH_WIDTH) :
        rename_pkg::dispatch_count_t'(count);

    always_ff @(posedge clock) begin
        if (reset) begin
            // Refill with ARCH_REGS..PHYS_REGS-1 in ascending order
            for (int i = 0; i < INITIAL_FREE; i++) begin
                free_regs[i] <= rename_pkg::phys_reg_idx'(`ARCH_REGS + i);
            end
            head <= '0;
            tail <= rename_pkg::phys_reg_idx'(INITIAL_FREE);
            count <= INITIAL_FREE[`FREE_COUNT_BITS-1:0];
        end else begin
            // A pushed register is visible at the head side next cycle
            if (free_valid) begin
                free_regs[tail] <= free_reg;
            end
            tail <= tail + free_valid;
            head <= head + regs_taken;
            count <= count + free_valid - regs_taken;
        end
    end

endmodule

// ==== rename_core.f ====
+incdir+common
common/rename_pkg.sv
dispatch/free_list.sv
dispatch/dispatch.sv
design/reorder_buffer.sv
design/rename_core.sv
bench/rename_core_assertions.sv
bench/rename_core_tb.sv
